// File: build.f
+incdir+source
source/fpu_mul_pkg.sv
source/sgf_partial_mult.sv
source/sgf_karatsuba.sv
source/exp_sign_unit.sv
source/round_normalize.sv
source/fpu_mul_top.sv
bench/fpu_mul_asserts.sv
bench/fpu_mul_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the multiplier testbench with verilator and run it
# a failing check ends the simulation with a nonzero status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module fpu_mul_tb \
    -f build.f \
    -o fpu_mul_sim

./obj_dir/fpu_mul_sim

// File: bench/fpu_mul_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_mul_consts.svh"

module fpu_mul_tb;

    localparam int SW = `FPM_SW;
    localparam int NUM_REQ = 2000;
    // three quarters load keeps the run near 2700 cycles
    localparam int CYCLE_LIMIT = 4 * NUM_REQ + 100;
    localparam logic [31:0] LFSR_SEED = 32'h3c34474f;
    // taps 32, 22, 2, 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clk = 1'b0;
    logic rst_n_i;
    logic valid_i;
    fpu_mul_pkg::mul_req_t req_i;
    logic valid_o;
    fpu_mul_pkg::mul_res_t res_o;

    logic [31:0] lfsr_state;
    int cycle = 0;
    int issued;
    int n_checked = 0;
    int n_ovf = 0;
    int n_unf = 0;
    fpu_mul_pkg::mul_req_t rq;

    // expected results and their issue cycles, oldest first
    fpu_mul_pkg::mul_res_t exp_q[$];
    int issue_q[$];
    fpu_mul_pkg::mul_res_t exp_res;
    int issue_cyc;

    fpu_mul_top uut (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .valid_i(valid_i),
        .req_i  (req_i),
        .valid_o(valid_o),
        .res_o  (res_o)
    );

    always #4 clk = ~clk;

    // galois step, shift right and fold the taps back in
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken, first bit ends up on top
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // random operand, skewed toward zeros, range extremes and rounding corners
    function automatic fpu_mul_pkg::fp32_t make_operand();
        fpu_mul_pkg::fp32_t op;
        logic [1:0] emode;
        logic [2:0] mmode;
        op.sign = 1'(rand_bits(1));
        emode = 2'(rand_bits(2));
        if (rand_bits(3) == 0) begin
            // flushed operand, mantissa may still look like a denormal
            op.exp = 8'd0;
        end else if (emode == 2'd0) begin
            // large, two of these can overflow
            op.exp = 8'd192 + 8'(rand_bits(6));
        end else if (emode == 2'd1) begin
            // small, two of these can underflow
            op.exp = 8'd1 + 8'(rand_bits(6));
        end else begin
            op.exp = 8'(rand_bits(8));
            if (op.exp == 8'd0)
                op.exp = 8'd1;
        end
        // field 255 is infinity or nan, never driven
        if (op.exp == 8'hff)
            op.exp = 8'hfe;
        mmode = 3'(rand_bits(3));
        case (mmode)
            3'd0: op.man = 23'h7fffff;
            // 0x7ffffe times 0x000001 lands just under 2.0, rounding carries
            3'd1: op.man = 23'h7ffffe;
            3'd2: op.man = 23'h000001;
            // short significands, products often end exactly on a tie
            3'd3: op.man = {12'(rand_bits(12)), 11'd0};
            default: op.man = 23'(rand_bits(23));
        endcase
        return op;
    endfunction

    // reference product, rounding by comparing the dropped bits with one half
    function automatic fpu_mul_pkg::mul_res_t model_mul(input fpu_mul_pkg::mul_req_t r_in);
        fpu_mul_pkg::mul_res_t r;
        logic [2*SW-1:0] p;
        logic [2*SW-1:0] kept;
        logic [2*SW-1:0] rem;
        logic [2*SW-1:0] half;
        int sh;
        int e;
        r = '0;
        r.value.sign = r_in.a.sign ^ r_in.b.sign;
        if (r_in.a.exp == 8'd0 || r_in.b.exp == 8'd0) begin
            return r;
        end
        p = {{SW{1'b0}}, 1'b1, r_in.a.man} * {{SW{1'b0}}, 1'b1, r_in.b.man};
        // value in [1,4) scaled by 2^46, keep 24 significant bits
        sh = p[2*SW-1] ? SW : SW - 1;
        e = int'(r_in.a.exp) + int'(r_in.b.exp) - `FPM_BIAS + (p[2*SW-1] ? 1 : 0);
        kept = p >> sh;
        rem = p - (kept << sh);
        half = {{(2*SW-1){1'b0}}, 1'b1} << (sh - 1);
        if (rem > half || (rem == half && kept[0])) begin
            kept = kept + 1'b1;
        end
        // rounded up to the next power of two
        if (kept[SW]) begin
            kept = kept >> 1;
            e = e + 1;
        end
        if (e >= 255) begin
            r.value.exp = 8'hff;
            r.overflow = 1'b1;
        end else if (e <= 0) begin
            r.underflow = 1'b1;
        end else begin
            r.value.exp = 8'(e);
            r.value.man = kept[`FPM_MAN_W-1:0];
        end
        return r;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "wrong value from the DUT");
        end
    endtask

    // cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("ERROR: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // outputs sampled mid cycle, well away from the driving edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            check_value(64'(valid_o), 64'd0, "valid_o during reset");
        end else if (valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: valid_o at %0t with no request outstanding", $time);
                $display("Simulation FAILED");
                $fatal(1, "unexpected result");
            end else begin
                exp_res = exp_q.pop_front();
                issue_cyc = issue_q.pop_front();
                check_value(64'(cycle - issue_cyc), 64'd3, "latency in cycles");
                check_value(64'(res_o.value), 64'(exp_res.value), "result value");
                check_value(64'(res_o.overflow), 64'(exp_res.overflow), "overflow flag");
                check_value(64'(res_o.underflow), 64'(exp_res.underflow), "underflow flag");
                n_checked++;
                if (exp_res.overflow)
                    n_ovf++;
                if (exp_res.underflow)
                    n_unf++;
            end
        end
    end

    initial begin
        lfsr_state = LFSR_SEED;
        rst_n_i = 1'b0;
        // strobes inside reset must never reach valid_o
        valid_i = 1'b1;
        req_i = '0;
        issued = 0;
        repeat (5) @(posedge clk);
        #1;
        // quiet tail so nothing is in flight when reset lifts
        valid_i = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        while (issued < NUM_REQ) begin
            @(posedge clk);
            #1;
            if (rand_bits(2) != 0) begin
                rq.a = make_operand();
                rq.b = make_operand();
                req_i = rq;
                valid_i = 1'b1;
                exp_q.push_back(model_mul(rq));
                issue_q.push_back(cycle);
                issued++;
            end else begin
                // idle cycle, operands are junk and must be ignored
                valid_i = 1'b0;
                req_i = {rand_bits(32), rand_bits(32)};
            end
        end
        @(posedge clk);
        #1;
        valid_i = 1'b0;
        // drain, then a few quiet cycles for stray strobes
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("checked %0d results, %0d overflow, %0d underflow", n_checked, n_ovf, n_unf);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/fpu_mul_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the multiplier top
module fpu_mul_asserts (
    input logic                  clk,
    input logic                  rst_n_i,
    input logic                  in_valid_i,
    input logic                  out_valid_i,
    input fpu_mul_pkg::mul_res_t res_i
);

    // one result per request, exactly three cycles later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i == $past(in_valid_i, 3))
        else $error("valid_o does not follow valid_i by three cycles");

    // strobe stays low while reset is held
    a_reset_quiet: assert property (@(posedge clk) !rst_n_i |=> !out_valid_i)
        else $error("valid_o high during reset");

    // a result is either too large or too small, never both
    a_flags: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i |-> !(res_i.overflow && res_i.underflow))
        else $error("overflow and underflow set together");

endmodule

bind fpu_mul_top fpu_mul_asserts u_asserts (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_valid_i (valid_i),
    .out_valid_i(valid_o),
    .res_i      (res_o)
);

`default_nettype wire

// File: source/fpu_mul_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_mul_consts.svh"

// pipelined single precision multiplier, one request per cycle
// fixed latency of three cycles from valid_i to valid_o
module fpu_mul_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  fpu_mul_pkg::mul_req_t req_i,
    output logic                  valid_o,
    output fpu_mul_pkg::mul_res_t res_o
);

    // significands with hidden bit restored
    logic [`FPM_SW-1:0] sig_a;
    logic [`FPM_SW-1:0] sig_b;

    // valid chain, bit 0 loads the product, bit 1 feeds rounding
    logic [1:0] vld_q;

    logic [2*`FPM_SW-1:0]    prod;
    fpu_mul_pkg::exp_stage_t exp_st;

    always_comb begin
        // zero exponent field means no hidden one
        sig_a = {|req_i.a.exp, req_i.a.man};
        sig_b = {|req_i.b.exp, req_i.b.man};
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld_q <= 2'b00;
        end else begin
            vld_q <= {vld_q[0], valid_i};
        end
    end

    sgf_karatsuba #(
        .SW(`FPM_SW)
    ) u_sgf (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .load_b_i    (vld_q[0]),
        .data_a_i    (sig_a),
        .data_b_i    (sig_b),
        .sgf_result_o(prod)
    );

    exp_sign_unit u_exp (
        .clk  (clk),
        .req_i(req_i),
        .exp_o(exp_st)
    );

    round_normalize u_rnd (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .valid_i(vld_q[1]),
        .prod_i (prod),
        .exp_i  (exp_st),
        .valid_o(valid_o),
        .res_o  (res_o)
    );

endmodule

`default_nettype wire

// File: source/round_normalize.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_mul_consts.svh"

// normalize the raw significand product, round to nearest even,
// then classify zero, overflow and underflow
module round_normalize (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic [2*`FPM_SW-1:0]      prod_i,
    input  fpu_mul_pkg::exp_stage_t   exp_i,
    output logic                      valid_o,
    output fpu_mul_pkg::mul_res_t     res_o
);

    localparam int SW = `FPM_SW;
    localparam int PW = 2 * SW;
    localparam int EW = `FPM_EXP_W + 2;

    // top bit of the product, product in [2,4)
    logic norm_hi;

    // significand before rounding, hidden bit included
    logic [SW-1:0] sig;
    logic          guard;
    logic          sticky;
    logic          round_up;

    // rounded significand with carry out
    logic [SW:0]   sig_rnd;
    logic [SW-1:0] sig_fin;

    // exponent after each adjustment
    logic signed [EW-1:0] exp_norm;
    logic signed [EW-1:0] exp_fin;

    fpu_mul_pkg::mul_res_t res_d;

    always_comb begin
        norm_hi = prod_i[PW-1];

        // pick the 24-bit window below the leading one
        if (norm_hi) begin
            sig    = prod_i[PW-1:SW];
            guard  = prod_i[SW-1];
            sticky = |prod_i[SW-2:0];
        end else begin
            sig    = prod_i[PW-2:SW-1];
            guard  = prod_i[SW-2];
            sticky = |prod_i[SW-3:0];
        end
        exp_norm = norm_hi ? exp_i.exp_sum + EW'(1) : exp_i.exp_sum;

        // nearest even, a tie goes up only on an odd lsb
        round_up = guard & (sticky | sig[0]);
        sig_rnd  = {1'b0, sig} + {{SW{1'b0}}, round_up};

        // all ones rolled over, renormalize by one
        if (sig_rnd[SW]) begin
            sig_fin = sig_rnd[SW:1];
            exp_fin = exp_norm + EW'(1);
        end else begin
            sig_fin = sig_rnd[SW-1:0];
            exp_fin = exp_norm;
        end
    end

    always_comb begin
        res_d.value.sign = exp_i.sign;
        res_d.overflow   = 1'b0;
        res_d.underflow  = 1'b0;

        if (exp_i.zero) begin
            // signed zero, no flags
            res_d.value.exp = '0;
            res_d.value.man = '0;
        end else if (exp_fin >= EW'(255)) begin
            // too large, signed infinity
            res_d.value.exp = '1;
            res_d.value.man = '0;
            res_d.overflow  = 1'b1;
        end else if (exp_fin <= EW'(0)) begin
            // too small, flushed since denormal results are not produced
            res_d.value.exp = '0;
            res_d.value.man = '0;
            res_d.underflow = 1'b1;
        end else begin
            res_d.value.exp = exp_fin[`FPM_EXP_W-1:0];
            res_d.value.man = sig_fin[`FPM_MAN_W-1:0];
        end
    end

    // output strobe
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // result captured only for a live operation
    always_ff @(posedge clk) begin
        if (valid_i) begin
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

// File: source/exp_sign_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_mul_consts.svh"

// sign and exponent path, two stages to match the significand product
module exp_sign_unit (
    input  logic                   clk,
    input  fpu_mul_pkg::mul_req_t  req_i,
    output fpu_mul_pkg::exp_stage_t exp_o
);

    // stage one result, before the register
    fpu_mul_pkg::exp_stage_t stage_d;
    // first pipeline register
    fpu_mul_pkg::exp_stage_t stage_q;

    always_comb begin
        // result sign
        stage_d.sign = req_i.a.sign ^ req_i.b.sign;

        // biased sum minus one bias
        // modular arithmetic, bit pattern is the signed value
        stage_d.exp_sum = (`FPM_EXP_W+2)'(req_i.a.exp)
                        + (`FPM_EXP_W+2)'(req_i.b.exp)
                        - (`FPM_EXP_W+2)'(`FPM_BIAS);

        // denormal inputs flushed, so any zero field means a zero operand
        stage_d.zero = (req_i.a.exp == '0) || (req_i.b.exp == '0);
    end

    // stage one
    always_ff @(posedge clk) begin
        stage_q <= stage_d;
    end

    // stage two, lines up with the karatsuba result register
    always_ff @(posedge clk) begin
        exp_o <= stage_q;
    end

endmodule

`default_nettype wire

// File: source/sgf_karatsuba.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_mul_consts.svh"

// karatsuba significand multiplier, one level of split
// three half-size products, recombined into a loadable result register
// expects an even SW
module sgf_karatsuba #(
    parameter int SW = `FPM_SW
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            load_b_i,
    input  logic [SW-1:0]   data_a_i,
    input  logic [SW-1:0]   data_b_i,
    output logic [2*SW-1:0] sgf_result_o
);

    localparam int H = SW / 2;

    // operand halves
    logic [H-1:0] a_hi;
    logic [H-1:0] a_lo;
    logic [H-1:0] b_hi;
    logic [H-1:0] b_lo;

    // half sums for the middle product, one carry bit
    logic [H:0] a_sum;
    logic [H:0] b_sum;

    // registered partial products
    logic [2*H-1:0] q_left;
    logic [2*H-1:0] q_right;
    logic [2*H+1:0] q_mid;

    // cross term and recombined product
    logic [2*H+1:0] mid_term;
    logic [2*SW-1:0] sum;

    always_comb begin
        a_hi = data_a_i[SW-1:H];
        a_lo = data_a_i[H-1:0];
        b_hi = data_b_i[SW-1:H];
        b_lo = data_b_i[H-1:0];
        a_sum = {1'b0, a_hi} + {1'b0, a_lo};
        b_sum = {1'b0, b_hi} + {1'b0, b_lo};
    end

    // high halves
    sgf_partial_mult #(
        .W(H)
    ) u_left (
        .clk     (clk),
        .data_a_i(a_hi),
        .data_b_i(b_hi),
        .prod_o  (q_left)
    );

    // low halves
    sgf_partial_mult #(
        .W(H)
    ) u_right (
        .clk     (clk),
        .data_a_i(a_lo),
        .data_b_i(b_lo),
        .prod_o  (q_right)
    );

    // (ah + al) * (bh + bl)
    sgf_partial_mult #(
        .W(H + 1)
    ) u_middle (
        .clk     (clk),
        .data_a_i(a_sum),
        .data_b_i(b_sum),
        .prod_o  (q_mid)
    );

    always_comb begin
        // ah*bl + al*bh, never negative
        mid_term = q_mid - {2'b00, q_left} - {2'b00, q_right};
        // left and right sit side by side, cross term shifted by H
        sum = {q_left, q_right}
            + {{(SW - H - 2){1'b0}}, mid_term, {H{1'b0}}};
    end

    // final product register
    // holds its value between load strobes
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sgf_result_o <= '0;
        end else if (load_b_i) begin
            sgf_result_o <= sum;
        end
    end

endmodule

`default_nettype wire

// File: source/sgf_partial_mult.sv
`timescale 1ns/1ps
`default_nettype none

// one registered W x W product
// used for the left, right and middle terms of the karatsuba split
module sgf_partial_mult #(
    parameter int W = 12
) (
    input  logic           clk,
    input  logic [W-1:0]   data_a_i,
    input  logic [W-1:0]   data_b_i,
    output logic [2*W-1:0] prod_o
);

    // full width product, never truncated
    logic [2*W-1:0] prod_d;

    always_comb begin
        // operands widened before the multiply
        prod_d = {{W{1'b0}}, data_a_i} * {{W{1'b0}}, data_b_i};
    end

    // single pipeline register
    always_ff @(posedge clk) begin
        prod_o <= prod_d;
    end

endmodule

`default_nettype wire

// File: source/fpu_mul_pkg.sv
`default_nettype none

`include "fpu_mul_consts.svh"

package fpu_mul_pkg;

    // packed ieee single, sign on top
    typedef struct packed {
        logic                  sign;
        logic [`FPM_EXP_W-1:0] exp;
        logic [`FPM_MAN_W-1:0] man;
    } fp32_t;

    // one multiply request, a in the upper half
    typedef struct packed {
        fp32_t a;
        fp32_t b;
    } mul_req_t;

    // sign and exponent record, travels beside the significand product
    // exp_sum is ea + eb - bias, two extra bits for range and sign
    typedef struct packed {
        logic                         sign;
        logic signed [`FPM_EXP_W+1:0] exp_sum;
        logic                         zero;
    } exp_stage_t;

    // final result with the range flags
    typedef struct packed {
        fp32_t value;
        logic  overflow;
        logic  underflow;
    } mul_res_t;

endpackage

`default_nettype wire

// File: source/fpu_mul_consts.svh
`ifndef FPU_MUL_CONSTS_SVH
`define FPU_MUL_CONSTS_SVH

// significand width with the hidden bit
`define FPM_SW 24

// biased exponent field
`define FPM_EXP_W 8

// stored mantissa, hidden bit dropped
`define FPM_MAN_W 23

// ieee single bias
`define FPM_BIAS 127

`endif
